/* include/cam_consts.svh */
//--------------------------------------------------------------------
// camera frame grabber constants
// image size, buffer geometry and frame sync filter length
//--------------------------------------------------------------------

`ifndef CAM_CONSTS_SVH
`define CAM_CONSTS_SVH

// image geometry, QQVGA halved
`define CAM_COLS 80 // pixels per line
`define CAM_ROWS 60 // lines per frame

// frame buffer, 80*60 = 4800 words fits in 13 bits
`define CAM_ADDR_W 13
`define CAM_LINE_W 7 // column or row index

// one buffer word, 4 bits each of red green blue
`define CAM_PIX_W 12

// vsync must stay high this many samples in a row
// shorter pulses are treated as glitches
`define CAM_VSYNC_LEN 4

`endif

/* hdl/cam_pkg.sv */
//--------------------------------------------------------------------
// camera frame grabber types
// vector widths, pixel formats, reader states and memory requests
//--------------------------------------------------------------------
`default_nettype none

`include "cam_consts.svh"

package cam_pkg;

  typedef logic [`CAM_ADDR_W-1:0] cam_addr_t; // frame buffer address
  typedef logic [`CAM_PIX_W-1:0]  cam_pix_t;  // {r,g,b} or gray in [7:0]
  typedef logic [7:0]             cam_byte_t; // one sensor byte
  typedef logic [`CAM_LINE_W-1:0] cam_line_t; // column or row index

  // how two sensor bytes turn into one buffer word
  typedef enum logic [2:0] {
    FMT_RGB444      = 3'd0,
    FMT_RGB555      = 3'd1,
    FMT_RGB565      = 3'd2,
    FMT_GRAY_FIRST  = 3'd3, // Y in byte 0
    FMT_GRAY_SECOND = 3'd4  // Y in byte 1
  } pix_fmt_t;

  typedef struct packed {
    logic      pclk;  // pixel (byte) clock, sampled only
    logic      href;  // line valid
    logic      vsync; // frame sync
    cam_byte_t data;
  } cam_pins_t;

  typedef struct packed {
    logic      we;    // single cycle strobe
    cam_addr_t addr;
    cam_pix_t  wdata;
  } mem_wr_t;

  typedef struct packed {
    logic      re;    // level, held until granted
    cam_addr_t addr;
  } mem_rd_t;

  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_OUT} rd_state_t;

endpackage

`default_nettype wire

/* hdl/cam_capture.sv */
//--------------------------------------------------------------------
// sensor capture
// samples the camera pins, pairs bytes into pixels, decodes the
// selected format and issues one buffer write per pixel
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cam_consts.svh"

module cam_capture (
  input  logic               rst,  // system clock
  input  logic               clk,  // async reset, active high
  input  cam_pkg::cam_pins_t pins, // raw sensor pins
  input  cam_pkg::pix_fmt_t  fmt,
  output cam_pkg::mem_wr_t   wr    // registered write request
);

  localparam int VS_W = $clog2(`CAM_VSYNC_LEN + 1);
  localparam logic [VS_W-1:0] VS_LAST = VS_W'(`CAM_VSYNC_LEN - 1);
  localparam logic [VS_W-1:0] VS_FULL = VS_W'(`CAM_VSYNC_LEN);
  localparam cam_pkg::cam_line_t NCOLS     = cam_pkg::cam_line_t'(`CAM_COLS);
  localparam cam_pkg::cam_addr_t LINE_STEP = cam_pkg::cam_addr_t'(`CAM_COLS);
  localparam cam_pkg::cam_addr_t FRAME_END = cam_pkg::cam_addr_t'(`CAM_COLS * `CAM_ROWS);

  cam_pkg::cam_pins_t s1, s2, s3; // synchronizer stages
  logic               pclk_rise;  // pclk rise at stage 2/3
  logic               href_fall;  // end of line
  logic               frame_sync; // filtered vsync, one cycle
  logic               byte_stb;   // a byte is valid in s2 this cycle
  logic [VS_W-1:0]    vs_cnt;     // consecutive vsync high samples
  logic               phase;      // 0: first byte, 1: second byte
  cam_pkg::cam_line_t col;        // pixel within the line
  cam_pkg::cam_addr_t line_base;  // address of column 0 of this line
  cam_pkg::cam_byte_t byte0;      // first byte of the pixel

  // two bytes -> one buffer word, red in the top nibble
  function automatic cam_pkg::cam_pix_t decode(input cam_pkg::pix_fmt_t  f,
                                               input cam_pkg::cam_byte_t b0,
                                               input cam_pkg::cam_byte_t b1);
    cam_pkg::cam_pix_t p;
    p = '0;
    case (f)
      cam_pkg::FMT_RGB444:      p = {b0[3:0], b1[7:4], b1[3:0]};
      cam_pkg::FMT_RGB555:      p = {b0[6:3], b0[1:0], b1[7:6], b1[4:1]}; // green split
      cam_pkg::FMT_RGB565:      p = {b0[7:4], b0[2:0], b1[7], b1[4:1]};   // green split
      cam_pkg::FMT_GRAY_FIRST:  p = {4'h0, b0};
      cam_pkg::FMT_GRAY_SECOND: p = {4'h0, b1};
      default:                  p = '0;
    endcase
    return p;
  endfunction

  //--------------------------------------------------------------------
  // pin synchronizer, three stages on every pin
  //--------------------------------------------------------------------
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      s1 <= '0;
      s2 <= '0;
      s3 <= '0;
    end else begin
      s1 <= pins;
      s2 <= s1;
      s3 <= s2;
    end
  end

  assign pclk_rise = s2.pclk & ~s3.pclk;
  assign href_fall = ~s2.href & s3.href;

  //--------------------------------------------------------------------
  // frame sync filter
  //--------------------------------------------------------------------
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      vs_cnt <= '0;
    end else if (!s3.vsync) begin
      vs_cnt <= '0; // glitch or end of sync, start over
    end else if (vs_cnt != VS_FULL) begin
      vs_cnt <= vs_cnt + VS_W'(1); // saturates, so sync fires once
    end
  end

  assign frame_sync = s3.vsync && (vs_cnt == VS_LAST);

  // data is taken from the same stage as the pclk edge, mid byte
  assign byte_stb = s2.href && pclk_rise && !frame_sync;

  //--------------------------------------------------------------------
  // byte pairing, line base and write request
  //--------------------------------------------------------------------
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      phase     <= 1'b0;
      col       <= '0;
      line_base <= '0;
      wr        <= '0;
    end else begin
      wr.we <= 1'b0; // strobe by default
      if (frame_sync) begin
        phase     <= 1'b0; // new frame restarts at address 0
        col       <= '0;
        line_base <= '0;
      end else if (href_fall) begin
        phase <= 1'b0;
        col   <= '0;
        // next line at row*80 even if this one was short or long
        if (line_base < FRAME_END) line_base <= line_base + LINE_STEP;
      end else if (byte_stb) begin
        phase <= ~phase;
        if (phase) begin
          if (col != NCOLS) col <= col + cam_pkg::cam_line_t'(1);
          // extra pixels and extra lines are dropped
          if (col < NCOLS && line_base < FRAME_END) begin
            wr.we    <= 1'b1;
            wr.addr  <= line_base + cam_pkg::cam_addr_t'(col);
            wr.wdata <= decode(fmt, byte0, s2.data);
          end
        end
      end
    end
  end

  // first byte held until its partner arrives
  always_ff @(posedge rst) begin
    if (byte_stb && !phase) byte0 <= s2.data;
  end

endmodule

`default_nettype wire

/* hdl/buf_arbiter.sv */
//--------------------------------------------------------------------
// frame buffer arbiter
// camera writes always take the port, the line reader waits for a
// free cycle and gets a registered grant
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module buf_arbiter (
  input  logic              rst,      // system clock
  input  logic              clk,      // async reset, active high
  input  cam_pkg::mem_wr_t  wr,       // from capture, we is a strobe
  input  cam_pkg::mem_rd_t  rd,       // from reader, re is held
  output logic              rd_grant, // one cycle, rdata valid now
  output logic              mem_en,
  output logic              mem_we,
  output cam_pkg::cam_addr_t mem_addr,
  output cam_pkg::cam_pix_t  mem_wdata
);

  logic rd_go; // read goes to the RAM this cycle

  // the cycle after a read is issued the reader still holds re
  // until it sees the grant, so that cycle must not reissue it
  assign rd_go = rd.re & ~wr.we & ~rd_grant;

  //--------------------------------------------------------------------
  // RAM port mux, write first
  //--------------------------------------------------------------------
  always_comb begin
    mem_en    = wr.we | rd_go;
    mem_we    = wr.we;
    mem_addr  = wr.we ? wr.addr : rd.addr;
    mem_wdata = wr.wdata; // don't care on reads
  end

  // grant lands with the RAM output register
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rd_grant <= 1'b0;
    end else begin
      rd_grant <= rd_go;
    end
  end

endmodule

`default_nettype wire

/* hdl/frame_buf.sv */
//--------------------------------------------------------------------
// frame buffer
// single port synchronous RAM, one word per pixel, registered read
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cam_consts.svh"

module frame_buf (
  input  logic               rst,   // system clock
  input  logic               en,
  input  logic               we,
  input  cam_pkg::cam_addr_t addr,
  input  cam_pkg::cam_pix_t  wdata,
  output cam_pkg::cam_pix_t  rdata  // holds until the next read
);

  localparam int DEPTH = `CAM_COLS * `CAM_ROWS;

  cam_pkg::cam_pix_t mem [0:DEPTH-1];

  always_ff @(posedge rst) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr]; // writes leave rdata alone
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/line_reader.sv */
//--------------------------------------------------------------------
// line reader
// reads one stored line through the arbiter and streams it out
// as pix_valid/pix_data, then pulses line_done
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cam_consts.svh"

module line_reader (
  input  logic               rst,        // system clock
  input  logic               clk,        // async reset, active high
  input  logic               line_start, // one cycle request
  input  cam_pkg::cam_line_t line_sel,   // row to read
  output cam_pkg::mem_rd_t   rd,
  input  logic               rd_grant,
  input  cam_pkg::cam_pix_t  rdata,
  output logic               pix_valid,
  output cam_pkg::cam_pix_t  pix_data,
  output logic               line_done
);

  localparam cam_pkg::cam_line_t LAST_COL = cam_pkg::cam_line_t'(`CAM_COLS - 1);

  cam_pkg::rd_state_t state;
  cam_pkg::cam_line_t col;  // column being read
  cam_pkg::cam_addr_t base; // row * 80

  assign rd.re   = (state == cam_pkg::RD_REQ);
  assign rd.addr = base + cam_pkg::cam_addr_t'(col);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state     <= cam_pkg::RD_IDLE;
      col       <= '0;
      pix_valid <= 1'b0;
      line_done <= 1'b0;
    end else begin
      pix_valid <= 1'b0;
      // only true right after the last word went out
      line_done <= pix_valid && (state == cam_pkg::RD_IDLE);
      case (state)
        cam_pkg::RD_IDLE: if (line_start) begin
          col   <= '0;
          state <= cam_pkg::RD_REQ;
        end
        cam_pkg::RD_REQ: if (rd_grant) state <= cam_pkg::RD_OUT; // re drops
        cam_pkg::RD_OUT: begin
          pix_valid <= 1'b1;
          if (col == LAST_COL) begin
            state <= cam_pkg::RD_IDLE;
          end else begin
            col   <= col + cam_pkg::cam_line_t'(1);
            state <= cam_pkg::RD_REQ;
          end
        end
        default: state <= cam_pkg::RD_IDLE;
      endcase
    end
  end

  // payload, no reset needed
  always_ff @(posedge rst) begin
    if (state == cam_pkg::RD_IDLE && line_start) begin
      base <= cam_pkg::cam_addr_t'(line_sel) * cam_pkg::cam_addr_t'(`CAM_COLS);
    end
    if (state == cam_pkg::RD_OUT) pix_data <= rdata; // RAM word held since grant
  end

endmodule

`default_nettype wire

/* hdl/cam_frame_top.sv */
//--------------------------------------------------------------------
// camera frame grabber top
// capture and line reader share one frame buffer through the arbiter
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cam_frame_top (
  input  logic               rst,        // system clock
  input  logic               clk,        // async reset, active high
  input  cam_pkg::cam_pins_t pins,       // sensor pins, unsynchronized
  input  cam_pkg::pix_fmt_t  fmt,
  input  logic               line_start,
  input  cam_pkg::cam_line_t line_sel,
  output logic               pix_valid,
  output cam_pkg::cam_pix_t  pix_data,
  output logic               line_done
);

  cam_pkg::mem_wr_t   wr;        // capture -> arbiter
  cam_pkg::mem_rd_t   rd;        // reader -> arbiter
  logic               rd_grant;
  logic               mem_en;
  logic               mem_we;
  cam_pkg::cam_addr_t mem_addr;
  cam_pkg::cam_pix_t  mem_wdata;
  cam_pkg::cam_pix_t  mem_rdata; // RAM -> reader

  cam_capture cam_capture_i (
    .rst  (rst),
    .clk  (clk),
    .pins (pins),
    .fmt  (fmt),
    .wr   (wr)
  );

  line_reader line_reader_i (
    .rst        (rst),
    .clk        (clk),
    .line_start (line_start),
    .line_sel   (line_sel),
    .rd         (rd),
    .rd_grant   (rd_grant),
    .rdata      (mem_rdata),
    .pix_valid  (pix_valid),
    .pix_data   (pix_data),
    .line_done  (line_done)
  );

  buf_arbiter buf_arbiter_i (
    .rst       (rst),
    .clk       (clk),
    .wr        (wr),
    .rd        (rd),
    .rd_grant  (rd_grant),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
  );

  frame_buf frame_buf_i (
    .rst   (rst),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* sim/cam_frame_props.sv */
//--------------------------------------------------------------------
// frame buffer arbiter assertions
// bound into buf_arbiter, checks port use and read grant latency
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cam_frame_props (
  input logic               rst,      // system clock
  input logic               clk,      // async reset, active high
  input cam_pkg::mem_wr_t   wr,
  input cam_pkg::mem_rd_t   rd,
  input logic               rd_grant,
  input logic               mem_en,
  input logic               mem_we,
  input cam_pkg::cam_addr_t mem_addr
);

  // a camera write takes the port in its own cycle
  we_needs_en: assert property (@(posedge rst) disable iff (clk)
    wr.we |-> mem_en && mem_we && mem_addr == wr.addr)
    else $error("camera write not passed to the buffer in its cycle");

  // grant answers a plain RAM read of the address the reader still holds
  grant_not_on_write: assert property (@(posedge rst) disable iff (clk)
    rd_grant |-> $past(mem_en && !mem_we) && $past(mem_addr) == rd.addr && rd.re)
    else $error("read grant without a clean read of the held address");

  // writes come at most every other cycle, so a held read waits 1 extra
  read_granted: assert property (@(posedge rst) disable iff (clk)
    (rd.re && !rd_grant) |-> ##[1:2] rd_grant)
    else $error("held read not granted within 2 cycles");

endmodule

`default_nettype wire

/* sim/cam_frame_tb.sv */
//--------------------------------------------------------------------
// camera frame grabber testbench
// sensor pin model, table of frames, line readback and scoreboard
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cam_consts.svh"

module cam_frame_tb;

  localparam int NROWS = 7;

  typedef struct packed {
    cam_pkg::pix_fmt_t  fmt;
    logic [7:0]         lines;    // lines sent in the frame
    cam_pkg::cam_line_t read_row; // line read back
    logic               glitch;   // 2 cycle vsync after line 1
    logic               overlap;  // read while the camera writes
  } test_row_t;

  logic               rst; // clock
  logic               clk; // reset
  cam_pkg::cam_pins_t pins;
  cam_pkg::pix_fmt_t  fmt;
  logic               line_start;
  cam_pkg::cam_line_t line_sel;
  logic               pix_valid;
  cam_pkg::cam_pix_t  pix_data;
  logic               line_done;

  test_row_t         table_rows [0:NROWS-1];
  cam_pkg::cam_pix_t model [0:`CAM_COLS*`CAM_ROWS-1]; // expected buffer contents
  cam_pkg::cam_pix_t exp_line [0:`CAM_COLS-1];
  cam_pkg::cam_pix_t got_q [$];                      // words seen on pix_data
  logic [31:0]       rng;
  int                err_cnt = 0;
  int                check_cnt = 0;
  int                valid_cnt = 0;
  int                done_cnt = 0;
  int                done_words = 0; // words seen before the last line_done
  int                cycle_cnt = 0;
  int                timeout_limit = 0;

  cam_frame_top cam_frame_top_i (
    .rst        (rst),
    .clk        (clk),
    .pins       (pins),
    .fmt        (fmt),
    .line_start (line_start),
    .line_sel   (line_sel),
    .pix_valid  (pix_valid),
    .pix_data   (pix_data),
    .line_done  (line_done)
  );

  bind buf_arbiter cam_frame_props props_i (
    .rst      (rst),
    .clk      (clk),
    .wr       (wr),
    .rd       (rd),
    .rd_grant (rd_grant),
    .mem_en   (mem_en),
    .mem_we   (mem_we),
    .mem_addr (mem_addr)
  );

  initial begin
    rst = 1'b0;
    forever #2 rst = ~rst; // 4 ns period
  end

  // output monitor, sampled away from the active edge
  always @(negedge rst) begin
    if (line_done) begin
      done_cnt++;
      done_words = got_q.size(); // a strobe in the same cycle is not counted
    end
    if (pix_valid) begin
      got_q.push_back(pix_data);
      valid_cnt++;
    end
  end

  always @(posedge rst) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit > 0 && cycle_cnt > timeout_limit) begin
      $display("ERROR: run did not finish within %0d cycles", timeout_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // reference word, fields picked from the two sensor bytes
  function automatic cam_pkg::cam_pix_t expect_word(input cam_pkg::pix_fmt_t  f,
                                                    input cam_pkg::cam_byte_t b0,
                                                    input cam_pkg::cam_byte_t b1);
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    r = b0[3:0];
    g = b1[7:4];
    b = b1[3:0];
    if (f == cam_pkg::FMT_RGB555) begin
      r = b0[6:3];
      g = {b0[1:0], b1[7:6]};
      b = b1[4:1];
    end else if (f == cam_pkg::FMT_RGB565) begin
      r = b0[7:4];
      g = {b0[2:0], b1[7]};
      b = b1[4:1];
    end
    if (f == cam_pkg::FMT_GRAY_FIRST) return {4'h0, b0};
    if (f == cam_pkg::FMT_GRAY_SECOND) return {4'h0, b1};
    return {r, g, b};
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_cnt++;
    if (expected !== actual) begin
      err_cnt++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  //--------------------------------------------------------------------
  // sensor pin model
  //--------------------------------------------------------------------
  task automatic send_byte(input cam_pkg::cam_byte_t b);
    @(posedge rst);
    pins.pclk <= 1'b0; // data changes while pclk is low
    pins.href <= 1'b1;
    pins.data <= b;
    repeat (2) @(posedge rst);
    pins.pclk <= 1'b1;
    @(posedge rst);
  endtask

  task automatic send_sync(input int len);
    @(posedge rst);
    pins.vsync <= 1'b1;
    repeat (len) @(posedge rst);
    pins.vsync <= 1'b0;
    repeat (8) @(posedge rst); // let the synchronizer drain
  endtask

  task automatic send_line(input int row, input cam_pkg::pix_fmt_t f);
    cam_pkg::cam_byte_t b0;
    cam_pkg::cam_byte_t b1;
    for (int c = 0; c < `CAM_COLS; c++) begin
      rng = xorshift32(rng);
      b0 = rng[7:0];
      rng = xorshift32(rng);
      b1 = rng[7:0];
      model[row * `CAM_COLS + c] = expect_word(f, b0, b1);
      send_byte(b0);
      send_byte(b1);
    end
    @(posedge rst);
    pins.pclk <= 1'b0;
    pins.href <= 1'b0; // falling href moves the line base
    repeat (6) @(posedge rst); // horizontal blanking
  endtask

  task automatic send_frame(input test_row_t t);
    @(posedge rst);
    fmt <= t.fmt;
    send_sync(6); // full frame sync
    for (int l = 0; l < int'(t.lines); l++) begin
      send_line(l, t.fmt);
      if (t.glitch && l == 1) send_sync(2); // too short to count
    end
  endtask

  //--------------------------------------------------------------------
  // line readback and scoreboard
  //--------------------------------------------------------------------
  task automatic load_expected(input cam_pkg::cam_line_t row);
    for (int c = 0; c < `CAM_COLS; c++) begin
      exp_line[c] = model[int'(row) * `CAM_COLS + c];
    end
  endtask

  task automatic read_line(input cam_pkg::cam_line_t row, input string name);
    int start_done;
    got_q.delete();
    start_done = done_cnt;
    @(posedge rst);
    line_start <= 1'b1;
    line_sel   <= row;
    @(posedge rst);
    line_start <= 1'b0;
    while (done_cnt == start_done) @(negedge rst); // watchdog covers a hang
    repeat (4) @(negedge rst); // stray strobes after line_done
    check({name, " words before line_done"}, `CAM_COLS, done_words);
    check({name, " word count"}, `CAM_COLS, got_q.size());
    check({name, " line_done pulses"}, 1, done_cnt - start_done);
    for (int c = 0; c < `CAM_COLS && c < got_q.size(); c++) begin
      check($sformatf("%s col %0d", name, c), exp_line[c], got_q[c]);
    end
  endtask

  initial begin
    test_row_t         t;
    cam_pkg::pix_fmt_t f;
    string             name;
    clk        = 1'b1;
    pins       = '0;
    fmt        = cam_pkg::FMT_RGB444;
    line_start = 1'b0;
    line_sel   = '0;
    rng        = 32'he826_7dd0;
    // fmt, lines, read row, glitch, overlap
    table_rows[0] = '{cam_pkg::FMT_RGB444,      8'd4, 7'd2, 1'b0, 1'b0};
    table_rows[1] = '{cam_pkg::FMT_RGB555,      8'd4, 7'd1, 1'b0, 1'b0};
    table_rows[2] = '{cam_pkg::FMT_RGB565,      8'd4, 7'd3, 1'b1, 1'b0};
    table_rows[3] = '{cam_pkg::FMT_GRAY_FIRST,  8'd3, 7'd0, 1'b0, 1'b0}; // overwrite from 0
    table_rows[4] = '{cam_pkg::FMT_GRAY_SECOND, 8'd5, 7'd4, 1'b1, 1'b0};
    table_rows[5] = '{cam_pkg::FMT_RGB565,      8'd3, 7'd3, 1'b0, 1'b1};
    table_rows[6] = '{cam_pkg::FMT_RGB444,      8'd2, 7'd4, 1'b0, 1'b1};
    timeout_limit = 2000;
    for (int i = 0; i < NROWS; i++) begin
      timeout_limit += int'(table_rows[i].lines) * `CAM_COLS * 8 + 1000;
    end

    repeat (2) @(posedge rst);
    clk <= 1'b0;
    repeat (20) @(posedge rst);
    check("idle after reset pix_valid", 0, valid_cnt);
    check("idle after reset line_done", 0, done_cnt);

    for (int i = 0; i < NROWS; i++) begin
      t = table_rows[i];
      f = t.fmt;
      name = $sformatf("row %0d %s line %0d", i, f.name(), t.read_row);
      if (t.overlap) begin
        load_expected(t.read_row); // line is not rewritten by this frame
        fork
          send_frame(t);
          begin
            repeat (100) @(posedge rst); // camera is inside line 0 by now
            read_line(t.read_row, name);
          end
        join
      end else begin
        send_frame(t);
        if (i == 0) begin
          check("idle during capture pix_valid", 0, valid_cnt);
          check("idle during capture line_done", 0, done_cnt);
        end
        load_expected(t.read_row);
        read_line(t.read_row, name);
      end
    end

    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
hdl/cam_pkg.sv
hdl/cam_capture.sv
hdl/buf_arbiter.sv
hdl/frame_buf.sv
hdl/line_reader.sv
hdl/cam_frame_top.sv
sim/cam_frame_props.sv
sim/cam_frame_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the camera frame grabber testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/cam_frame_sim

verilator --binary --timing --assert \
  -f src.f \
  --top-module cam_frame_tb \
  -Mdir obj_dir \
  -o cam_frame_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see $BUILD_LOG"
  exit 1
fi

"./$SIM_BIN" > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see $SIM_LOG"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$SIM_LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $SIM_LOG"
exit 1
